/* run_sim.sh */
#!/bin/bash
# build the revo encoder testbench with Verilator and run it
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module revo_encoder_tb \
	-f tb.f -o revo_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/revo_sim > sim.log 2>&1
cat sim.log

grep -qx "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb.f */
verilog/revo_pkg.sv
verilog/revo_stream_sampler.sv
verilog/synchronizer_fast_to_slow.sv
verilog/revo_decider.sv
verilog/trigger_encoder.sv
verilog/revo_encoder_top.sv
verif/revo_encoder_props.sv
verif/revo_encoder_tb.sv

/* verif/revo_encoder_props.sv */
`timescale 1ns/1ps

module revo_encoder_props (
	input logic clock254,
	input logic reset,
	input logic should_trigger,
	input logic frame_marker,
	input logic clock127_out,
	input logic trg_out,
	input revo_pkg::revo_status_t status
);

	// clock254 cycles since reset, saturating
	logic [3:0] settle;
	logic settled;

	// number of failed assertions
	int failures = 0;

	always_ff @(posedge clock254) begin
		if (reset) begin
			settle <= '0;
		end else if (settle != 4'hf) begin
			settle <= settle + 4'd1;
		end
	end

	// frame rotation is running and the status register has followed it
	assign settled = (settle >= 4'd8);

	// --------------------
	// reference and frame grid

	clock127_toggles: assert property (@(posedge clock254) disable iff (reset)
		!$past(reset) |-> clock127_out != $past(clock127_out))
		else begin
			failures++;
			$error("clock127_out did not toggle on a clock254 cycle");
		end

	frame_marker_period: assert property (@(posedge clock254) disable iff (reset)
		settled |-> status.frame_marker == $past(status.frame_marker, 4))
		else begin
			failures++;
			$error("status.frame_marker does not repeat every 4 cycles");
		end

	frame_marker_single: assert property (@(posedge clock254) disable iff (reset)
		settled && status.frame_marker |-> !$past(status.frame_marker))
		else begin
			failures++;
			$error("status.frame_marker is longer than one cycle");
		end

	frame_marker_present: assert property (@(posedge clock254) disable iff (reset)
		settled |-> (status.frame_marker || $past(status.frame_marker)
			|| $past(status.frame_marker, 2) || $past(status.frame_marker, 3)))
		else begin
			failures++;
			$error("no status.frame_marker pulse within 4 cycles");
		end

	// --------------------
	// trigger frames

	// trg_out stands still exactly on the cycles after should_trigger
	trg_hold_follows_trigger: assert property (@(posedge clock254) disable iff (reset)
		!$past(reset) |-> (trg_out == $past(trg_out)) == $past(should_trigger))
		else begin
			failures++;
			$error("trg_out hold does not match the trigger level");
		end

	trigger_on_frame_grid: assert property (@(posedge clock254) disable iff (reset)
		settled && !frame_marker |-> should_trigger == $past(should_trigger))
		else begin
			failures++;
			$error("should_trigger changed inside a frame");
		end

	trigger_not_adjacent: assert property (@(posedge clock254) disable iff (reset)
		settled && frame_marker && should_trigger |-> !$past(should_trigger))
		else begin
			failures++;
			$error("two trigger frames in a row");
		end

endmodule

bind trigger_encoder revo_encoder_props encoder_props (
	.clock254(clock254),
	.reset(reset),
	.should_trigger(should_trigger),
	.frame_marker(frame_marker),
	.clock127_out(clock127_out),
	.trg_out(trg_out),
	.status(status)
);

/* verif/revo_encoder_tb.sv */
`timescale 1ns/1ps

module revo_encoder_tb;

	// pulse width and quiet gap in clock509 samples,
	// then the triggers that pulse should add
	typedef struct packed {
		int pulse_len;
		int gap_len;
		int new_triggers;
	} stim_row_t;

	localparam int row_count = 12;
	// quiet gap that separates independent trigger groups
	localparam int group_gap = 24;
	// clock509 cycles allowed for a pending trigger to come out
	localparam int trigger_wait = 64;

	logic clock254;
	logic clock509;
	logic reset;
	logic revo_in;
	logic clock127_out;
	logic trg_out;
	revo_pkg::revo_status_t status;

	stim_row_t stim_table [row_count];
	logic table_loaded = 1'b0;
	int error_count = 0;
	int check_count = 0;

	revo_encoder_top #(
		.trgstream_width(revo_pkg::trgstream_width),
		.trg_max_duration(revo_pkg::trg_max_duration),
		.count_width(revo_pkg::count_width)
	) DUT (
		.clock254(clock254),
		.clock509(clock509),
		.reset(reset),
		.revo_in(revo_in),
		.clock127_out(clock127_out),
		.trg_out(trg_out),
		.status(status)
	);

	// --------------------
	// clocks, rising edges of both line up
	initial begin
		clock254 = 1'b0;
		clock509 = 1'b0;
		forever begin
			#5;
			clock254 = ~clock254;
			clock509 = ~clock509;
			#5;
			clock509 = ~clock509;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual,
				expected);
		end
	endtask

	task automatic load_table();
		// isolated pulses of several widths
		stim_table[0] = '{pulse_len: 1, gap_len: 40, new_triggers: 1};
		stim_table[1] = '{pulse_len: 2, gap_len: 40, new_triggers: 1};
		stim_table[2] = '{pulse_len: 5, gap_len: 30, new_triggers: 1};
		stim_table[3] = '{pulse_len: 8, gap_len: 32, new_triggers: 1};
		stim_table[4] = '{pulse_len: 13, gap_len: 24, new_triggers: 1};
		// revo held high over many frames
		stim_table[5] = '{pulse_len: 200, gap_len: 40, new_triggers: 1};
		// three short pulses packed inside one 16-sample window
		stim_table[6] = '{pulse_len: 1, gap_len: 2, new_triggers: 1};
		stim_table[7] = '{pulse_len: 2, gap_len: 3, new_triggers: 0};
		stim_table[8] = '{pulse_len: 1, gap_len: 40, new_triggers: 0};
		stim_table[9] = '{pulse_len: 3, gap_len: 30, new_triggers: 1};
		stim_table[10] = '{pulse_len: 1, gap_len: 24, new_triggers: 1};
		stim_table[11] = '{pulse_len: 4, gap_len: 50, new_triggers: 1};
	endtask

	task automatic drive_level(input logic level, input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(posedge clock509);
			revo_in <= level;
		end
	endtask

	// wait until the count reaches target, bounded by trigger_wait
	task automatic wait_for_count(input int target);
		int waited;
		waited = 0;
		@(negedge clock509);
		while (int'(status.trigger_count) < target && waited < trigger_wait) begin
			@(negedge clock509);
			waited++;
		end
		if (int'(status.trigger_count) < target) begin
			error_count++;
			$display("ERROR at %0t: trigger_count stayed below %0d for %0d clock509 cycles",
				$time, target, trigger_wait);
		end
	endtask

	// --------------------
	// output monitor, mid-cycle on clock254
	initial begin : frame_monitor
		logic prev_trg;
		logic have_prev;
		int run_len;
		int quiet_len;
		int runs_seen;
		have_prev = 1'b0;
		prev_trg = 1'b0;
		run_len = 0;
		quiet_len = 4;
		runs_seen = 0;
		forever begin
			@(negedge clock254);
			if (reset) begin
				have_prev = 1'b0;
			end else begin
				if (have_prev) begin
					if (trg_out == prev_trg) begin
						// trg_out held, inside a trigger frame
						if (run_len == 0) begin
							runs_seen++;
							if (runs_seen > 1 && quiet_len < 4) begin
								error_count++;
								$display("ERROR at %0t: trigger frame follows the previous one directly",
									$time);
							end
						end
						run_len++;
						if (run_len == 5) begin
							error_count++;
							$display("ERROR at %0t: trg_out held for more than 4 cycles", $time);
						end
					end else begin
						if (run_len != 0) begin
							check_value("trg_out hold length", 32'(run_len), 32'd4);
							run_len = 0;
							quiet_len = 0;
						end
						quiet_len++;
						// outside a trigger both lines run in phase
						check_value("trg_out", 32'(trg_out), 32'(clock127_out));
					end
					check_value("status.trigger_count", 32'(status.trigger_count), 32'(runs_seen));
				end
				prev_trg = trg_out;
				have_prev = 1'b1;
			end
		end
	end

	// --------------------
	// stimulus and verdict
	initial begin : main_sequence
		int expected_total;
		int offset;
		int row;
		int assert_failures;
		logic realign;
		reset = 1'b1;
		revo_in = 1'b0;
		expected_total = 0;
		realign = 1'b1;
		void'($urandom(32'hdd69));
		load_table();
		table_loaded = 1'b1;
		repeat (16) @(posedge clock254);
		reset <= 1'b0;
		@(posedge clock254);
		@(negedge clock254);
		check_value("status.trigger_count", 32'(status.trigger_count), 32'd0);
		check_value("trg_out", 32'(trg_out), 32'(clock127_out));
		for (row = 0; row < row_count; row++) begin
			offset = int'($urandom_range(7, 0));
			// shift against the frame grid only where the stream is quiet
			if (realign) begin
				drive_level(1'b0, offset);
			end
			drive_level(1'b1, stim_table[row].pulse_len);
			drive_level(1'b0, stim_table[row].gap_len);
			expected_total += stim_table[row].new_triggers;
			realign = (stim_table[row].gap_len >= group_gap);
			if (realign) begin
				wait_for_count(expected_total);
				check_value("status.trigger_count", 32'(status.trigger_count),
					32'(expected_total));
			end
		end
		// drain, nothing more may arrive
		drive_level(1'b0, trigger_wait);
		@(negedge clock254);
		check_value("final status.trigger_count", 32'(status.trigger_count),
			32'(expected_total));
		assert_failures = DUT.encoder.encoder_props.failures;
		$display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
			assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// --------------------
	// watchdog
	initial begin : watchdog
		int limit_ns;
		int row;
		wait (table_loaded);
		limit_ns = 2000;
		for (row = 0; row < row_count; row++) begin
			// row length includes room for the random offset
			limit_ns += (stim_table[row].pulse_len + stim_table[row].gap_len + 8) * 10;
		end
		#(limit_ns);
		$display("ERROR: watchdog expired after %0d ns, the test did not finish", limit_ns);
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verilog/revo_decider.sv */
`timescale 1ns/1ps

module revo_decider #(
	parameter int trgstream_width = revo_pkg::trgstream_width,
	parameter int trg_max_duration = revo_pkg::trg_max_duration
) (
	input logic clock254,
	input logic reset,
	input logic [trgstream_width-1:0] trgstream_slow,
	output logic should_trigger,
	output logic frame_marker
);

	localparam int upper_width = trgstream_width - trg_max_duration;

	revo_pkg::frame_phase_t phase;

	// stream halves captured at the latch phase
	logic [upper_width-1:0] upper;
	logic [trg_max_duration-1:0] lower;

	// reduced halves
	logic upper_any;
	logic lower_any;

	// decision being built for the next frame
	logic armed;

	// --------------------
	// frame rotation
	always_ff @(posedge clock254) begin
		if (reset) begin
			phase <= revo_pkg::phase_latch;
		end else begin
			phase <= revo_pkg::next_phase(phase);
		end
	end

	// both halves, once per frame
	always_ff @(posedge clock254) begin
		if (phase == revo_pkg::phase_latch) begin
			upper <= trgstream_slow[trgstream_width-1:trg_max_duration];
			lower <= trgstream_slow[trg_max_duration-1:0];
		end
	end

	// --------------------
	// decision
	always_ff @(posedge clock254) begin
		if (reset) begin
			upper_any <= 1'b0;
			lower_any <= 1'b0;
			armed <= 1'b0;
			should_trigger <= 1'b0;
			frame_marker <= 1'b0;
		end else begin
			// one-cycle pulse, lines up with the first cycle of should_trigger
			frame_marker <= (phase == revo_pkg::phase_latch);
			case (phase)
				revo_pkg::phase_latch: begin
					// previous frame's verdict, held for the whole frame
					should_trigger <= armed;
				end
				revo_pkg::phase_reduce: begin
					upper_any <= |upper;
					lower_any <= |lower;
				end
				revo_pkg::phase_arm: begin
					// any new sample high
					armed <= lower_any;
				end
				revo_pkg::phase_veto: begin
					// old half already high, so this is not an onset
					if (upper_any) begin
						armed <= 1'b0;
					end
				end
				default: begin
					armed <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* verilog/revo_encoder_top.sv */
`timescale 1ns/1ps

module revo_encoder_top #(
	parameter int trgstream_width = revo_pkg::trgstream_width,
	parameter int trg_max_duration = revo_pkg::trg_max_duration,
	parameter int count_width = revo_pkg::count_width
) (
	input logic clock254,
	input logic clock509,
	input logic reset,
	input logic revo_in,
	output logic clock127_out,
	output logic trg_out,
	output revo_pkg::revo_status_t status
);

	logic [trgstream_width-1:0] trgstream_fast;
	logic [trgstream_width-1:0] trgstream_slow;
	logic should_trigger;
	logic frame_marker;

	// --------------------
	// clock509 domain
	revo_stream_sampler #(
		.trgstream_width(trgstream_width)
	) sampler (
		.clock509(clock509),
		.reset(reset),
		.revo_in(revo_in),
		.trgstream_fast(trgstream_fast)
	);

	synchronizer_fast_to_slow #(
		.WIDTH(trgstream_width)
	) ts_sync (
		.faster_clock(clock509),
		.slower_clock(clock254),
		.reset(reset),
		.in(trgstream_fast),
		.out(trgstream_slow)
	);

	// --------------------
	// clock254 domain
	revo_decider #(
		.trgstream_width(trgstream_width),
		.trg_max_duration(trg_max_duration)
	) decider (
		.clock254(clock254),
		.reset(reset),
		.trgstream_slow(trgstream_slow),
		.should_trigger(should_trigger),
		.frame_marker(frame_marker)
	);

	trigger_encoder #(
		.count_width(count_width)
	) encoder (
		.clock254(clock254),
		.reset(reset),
		.should_trigger(should_trigger),
		.frame_marker(frame_marker),
		.clock127_out(clock127_out),
		.trg_out(trg_out),
		.status(status)
	);

endmodule

/* verilog/revo_pkg.sv */
package revo_pkg;

	// --------------------
	// trigger stream geometry

	// clock509 samples held in the trigger stream
	localparam int trgstream_width = 16;
	// newest half of the stream, the only part that can start a trigger
	localparam int trg_max_duration = 8;
	// width of the issued trigger counter
	localparam int count_width = 16;

	// --------------------
	// frame phases

	// one-hot, rotates once per clock254 cycle
	typedef enum logic [3:0] {
		phase_latch  = 4'b0001,
		phase_reduce = 4'b0010,
		phase_arm    = 4'b0100,
		phase_veto   = 4'b1000
	} frame_phase_t;

	// next phase in the four-cycle rotation
	function automatic frame_phase_t next_phase(input frame_phase_t phase);
		logic [3:0] bits;
		bits = phase;
		return frame_phase_t'({bits[2:0], bits[3]});
	endfunction

	// --------------------
	// status

	typedef struct packed {
		// registered copy of the decider frame pulse
		logic frame_marker;
		// frames issued with a trigger since reset
		logic [count_width-1:0] trigger_count;
	} revo_status_t;

endpackage

/* verilog/revo_stream_sampler.sv */
`timescale 1ns/1ps

module revo_stream_sampler #(
	parameter int trgstream_width = revo_pkg::trgstream_width
) (
	input logic clock509,
	input logic reset,
	input logic revo_in,
	output logic [trgstream_width-1:0] trgstream_fast
);

	// raw revo level, fine timing at twice the system rate
	logic [trgstream_width-1:0] stream;

	// newest sample enters at bit 0, oldest falls off the top
	always_ff @(posedge clock509) begin
		if (reset) begin
			stream <= '0;
		end else begin
			stream <= {stream[trgstream_width-2:0], revo_in};
		end
	end

	assign trgstream_fast = stream;

endmodule

/* verilog/synchronizer_fast_to_slow.sv */
`timescale 1ns/1ps

module synchronizer_fast_to_slow #(
	parameter int WIDTH = 1
) (
	input logic faster_clock,
	input logic slower_clock,
	input logic reset,
	input logic [WIDTH-1:0] in,
	output logic [WIDTH-1:0] out
);

	logic [WIDTH-1:0] stage_f1;
	logic [WIDTH-1:0] stage_f2;
	logic [WIDTH-1:0] stage_s1;
	logic [WIDTH-1:0] stage_s2;

	// crossing point between the two clock domains
	logic [WIDTH-1:0] cdc;

	// --------------------
	// fast side
	always_ff @(posedge faster_clock) begin
		if (reset) begin
			stage_f1 <= '0;
			stage_f2 <= '0;
		end else begin
			stage_f1 <= in;
			stage_f2 <= stage_f1;
		end
	end

	assign cdc = stage_f2;

	// --------------------
	// slow side
	always_ff @(posedge slower_clock) begin
		if (reset) begin
			stage_s1 <= '0;
			stage_s2 <= '0;
		end else begin
			stage_s1 <= cdc;
			stage_s2 <= stage_s1;
		end
	end

	assign out = stage_s2;

endmodule

/* verilog/trigger_encoder.sv */
`timescale 1ns/1ps

module trigger_encoder #(
	parameter int count_width = revo_pkg::count_width
) (
	input logic clock254,
	input logic reset,
	input logic should_trigger,
	input logic frame_marker,
	output logic clock127_out,
	output logic trg_out,
	output revo_pkg::revo_status_t status
);

	logic clock127;
	logic trg_line;
	logic marker_q;
	logic [count_width-1:0] trigger_count;

	// a trigger frame starts where the marker and the level coincide
	logic trigger_start;

	assign trigger_start = should_trigger & frame_marker;

	// --------------------
	// clock127 reference and encoded trigger
	always_ff @(posedge clock254) begin
		if (reset) begin
			clock127 <= 1'b0;
			trg_line <= 1'b0;
		end else begin
			clock127 <= ~clock127;
			// trg_line stops while a trigger is active, so
			// clock127 ^ trg_line goes high only inside those cycles
			if (!should_trigger) begin
				trg_line <= ~trg_line;
			end
		end
	end

	// --------------------
	// status
	always_ff @(posedge clock254) begin
		if (reset) begin
			marker_q <= 1'b0;
			trigger_count <= '0;
		end else begin
			marker_q <= frame_marker;
			if (trigger_start) begin
				trigger_count <= trigger_count + 1'b1;
			end
		end
	end

	assign clock127_out = clock127;
	assign trg_out = trg_line;

	assign status.frame_marker = marker_q;
	assign status.trigger_count = trigger_count;

endmodule
